//--- hw/qla_consts.svh
`ifndef QLA_CONSTS_SVH
`define QLA_CONSTS_SVH

// --------------------------------------------------------------------------
// register address fields, used as slice ranges
// --------------------------------------------------------------------------
`define ADDR_SPACE      15:12   // address space select
`define ADDR_CHAN       7:4     // channel, 0 is the board channel
`define ADDR_OFF        3:0     // offset within a channel

`define ADDR_MAIN       4'h0    // main register space
`define CHAN_BOARD      4'h0    // channel 0
`define REG_STATUS      4'h0    // status register in channel 0
`define OFF_DAC_CTRL    4'h1    // dac current command, axis channels

`define NUM_AXES        4

// --------------------------------------------------------------------------
// status word layout
// --------------------------------------------------------------------------
`define STAT_DIS_LSB    0       // safety disables, 4 bits
`define STAT_AMP_LSB    8       // amp enables, 4 bits
`define STAT_PWR_BIT    19      // power enable
`define STAT_ID_LSB     24      // board id, 4 bits

// consecutive overcurrent samples before the amp is shut off
`define SAFETY_LIMIT    8

`endif

//--- hw/bus_pkg.sv
// register bus shared by the firewire and ethernet masters

package bus_pkg;

    // address layout
    //   [15:12] space
    //   [7:4]   channel
    //   [3:0]   offset
    typedef logic [15:0] reg_addr_t;

    // one quadlet of register data
    typedef logic [31:0] reg_data_t;

    // decoded address fields
    typedef logic [3:0] chan_t;     // channel number
    typedef logic [3:0] off_t;      // offset in channel

endpackage

//--- hw/motor_pkg.sv
// axis side types: currents, per-axis masks, board id

package motor_pkg;

    // dac command and adc feedback, both unsigned here
    typedef logic [15:0] current_t;

    // one extra bit so 2x command does not overflow
    typedef logic [16:0] cur_wide_t;

    // bit 0 is axis 1
    typedef logic [3:0] axis_mask_t;

    typedef logic [3:0] board_id_t;     // rotary switch value

endpackage

//--- hw/bus_arbiter.sv
`timescale 1ns/100ps

// stage 1: picks the bus master for writes and reads, then registers
// the result onto the internal bus

module bus_arbiter import bus_pkg::*; (
    input  logic      sysclk,
    input  logic      arst_n,

    // firewire master, default owner
    input  logic      fw_reg_wen,       // one cycle strobe
    input  reg_addr_t fw_reg_waddr,
    input  reg_data_t fw_reg_wdata,
    input  reg_addr_t fw_reg_raddr,

    // ethernet master
    input  logic      eth_reg_wen,      // one cycle strobe
    input  reg_addr_t eth_reg_waddr,
    input  reg_data_t eth_reg_wdata,
    input  logic      eth_read_en,      // level, holds the read path
    input  reg_addr_t eth_reg_raddr,

    // internal bus
    output logic      bus_wen,
    output reg_addr_t bus_waddr,
    output reg_data_t bus_wdata,
    output reg_addr_t bus_raddr
);

    reg_addr_t waddr_sel;   // winning write address
    reg_data_t wdata_sel;   // winning write data
    reg_addr_t raddr_sel;

    // ethernet wins a same-cycle collision
    assign waddr_sel = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign wdata_sel = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
    assign raddr_sel = eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    // strobe and read address carry control
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            bus_wen   <= 1'b0;
            bus_raddr <= '0;
        end else begin
            bus_wen   <= fw_reg_wen | eth_reg_wen;
            bus_raddr <= raddr_sel;
        end
    end

    // write payload, qualified by bus_wen downstream
    always_ff @(posedge sysclk) begin
        bus_waddr <= waddr_sel;
        bus_wdata <= wdata_sel;
    end

endmodule

//--- hw/channel_regs.sv
`timescale 1ns/100ps

`include "qla_consts.svh"

// stage 2: main-space decode, dac command and status registers, read mux

module channel_regs import bus_pkg::*, motor_pkg::*; (
    input  logic       sysclk,
    input  logic       arst_n,
    input  logic       bus_wen,
    input  reg_addr_t  bus_waddr,
    input  reg_data_t  bus_wdata,
    input  reg_addr_t  bus_raddr,
    input  board_id_t  board_id,
    input  axis_mask_t safety_disable,     // latched trips from stage 3
    output current_t   cur_cmd [`NUM_AXES],
    output axis_mask_t clear_disable,      // one cycle pulse per axis
    output axis_mask_t amp_enable,
    output reg_data_t  reg_rdata
);

    chan_t      w_chan;
    off_t       w_off;
    logic       w_main;         // write strobe in main space
    logic       w_status;       // status register hit
    axis_mask_t w_dac;          // dac register hit, per axis
    chan_t      r_chan;
    off_t       r_off;
    logic       pwr_en;         // power enable command
    axis_mask_t amp_en_cmd;     // amp enable commands
    reg_data_t  status_word;
    reg_data_t  rdata_nxt;

    // ----------------------------------------------------------------------
    // write decode
    // ----------------------------------------------------------------------
    assign w_chan   = bus_waddr[`ADDR_CHAN];
    assign w_off    = bus_waddr[`ADDR_OFF];
    assign w_main   = bus_wen && (bus_waddr[`ADDR_SPACE] == `ADDR_MAIN);
    assign w_status = w_main && (w_chan == `CHAN_BOARD) && (w_off == `REG_STATUS);

    always_comb begin
        for (int i = 0; i < `NUM_AXES; i++) begin
            // axis channels are numbered from 1
            w_dac[i] = w_main && (w_chan == chan_t'(i + 1)) && (w_off == `OFF_DAC_CTRL);
        end
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                cur_cmd[i] <= '0;
            end
            pwr_en        <= 1'b0;
            amp_en_cmd    <= '0;
            clear_disable <= '0;
        end else begin
            for (int i = 0; i < `NUM_AXES; i++) begin
                if (w_dac[i]) begin
                    cur_cmd[i] <= bus_wdata[15:0];      // low half only
                end
            end
            clear_disable <= '0;                        // pulse by default
            if (w_status) begin
                pwr_en     <= bus_wdata[`STAT_PWR_BIT];
                amp_en_cmd <= bus_wdata[`STAT_AMP_LSB +: `NUM_AXES];
                // enabling an amp, or power, re-arms its safety check
                clear_disable <= bus_wdata[`STAT_AMP_LSB +: `NUM_AXES]
                               | {`NUM_AXES{bus_wdata[`STAT_PWR_BIT]}};
            end
        end
    end

    // tripped axis is held off until re-enabled
    assign amp_enable = amp_en_cmd & {`NUM_AXES{pwr_en}} & ~safety_disable;

    // ----------------------------------------------------------------------
    // read side
    // ----------------------------------------------------------------------
    always_comb begin
        status_word = '0;
        status_word[`STAT_ID_LSB +: $bits(board_id_t)] = board_id;
        status_word[`STAT_PWR_BIT]                     = pwr_en;
        status_word[`STAT_AMP_LSB +: `NUM_AXES]        = amp_en_cmd;    // commanded bits
        status_word[`STAT_DIS_LSB +: `NUM_AXES]        = safety_disable;
    end

    assign r_chan = bus_raddr[`ADDR_CHAN];
    assign r_off  = bus_raddr[`ADDR_OFF];

    always_comb begin
        rdata_nxt = '0;                     // unmapped reads give zero
        if (bus_raddr[`ADDR_SPACE] == `ADDR_MAIN) begin
            if (r_chan == `CHAN_BOARD && r_off == `REG_STATUS) begin
                rdata_nxt = status_word;
            end
            for (int i = 0; i < `NUM_AXES; i++) begin
                if (r_chan == chan_t'(i + 1) && r_off == `OFF_DAC_CTRL) begin
                    rdata_nxt = {16'h0000, cur_cmd[i]};
                end
            end
        end
    end

    // second pipeline register on the read path
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rdata_nxt;
        end
    end

endmodule

//--- hw/safety_check.sv
`timescale 1ns/100ps

`include "qla_consts.svh"

// stage 3: per-axis overcurrent check
// trips when feedback stays above twice the command for SAFETY_LIMIT samples

module safety_check import motor_pkg::*; (
    input  logic     sysclk,
    input  logic     arst_n,
    input  current_t cur_fb,            // adc feedback
    input  current_t cur_cmd,           // dac command
    input  logic     clear_disable,     // one cycle re-arm
    output logic     amp_disable        // latched trip
);

    localparam int CNT_W = $clog2(`SAFETY_LIMIT + 1);

    cur_wide_t        fb_ext;
    cur_wide_t        limit_ext;    // 2x command
    logic             viol;
    logic [CNT_W-1:0] viol_cnt;     // consecutive violations, saturates

    assign fb_ext    = {1'b0, cur_fb};
    assign limit_ext = {cur_cmd, 1'b0};
    assign viol      = fb_ext > limit_ext;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            // clear wins over a violation in the same cycle
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (viol) begin
            if (viol_cnt != CNT_W'(`SAFETY_LIMIT)) begin
                viol_cnt <= viol_cnt + 1'b1;
            end
            if (viol_cnt >= CNT_W'(`SAFETY_LIMIT - 1)) begin
                amp_disable <= 1'b1;        // limit-th sample lands here
            end
        end else begin
            viol_cnt <= '0;                 // run broken, latch holds
        end
    end

endmodule

//--- hw/qla_reg_core.sv
`timescale 1ns/100ps

`include "qla_consts.svh"

// register bus core: arbiter -> channel registers -> safety checks

module qla_reg_core import bus_pkg::*, motor_pkg::*; (
    input  logic       sysclk,
    input  logic       arst_n,
    input  logic       fw_reg_wen,
    input  reg_addr_t  fw_reg_waddr,
    input  reg_data_t  fw_reg_wdata,
    input  reg_addr_t  fw_reg_raddr,
    input  logic       eth_reg_wen,
    input  reg_addr_t  eth_reg_waddr,
    input  reg_data_t  eth_reg_wdata,
    input  logic       eth_read_en,
    input  reg_addr_t  eth_reg_raddr,
    input  board_id_t  board_id,
    input  current_t   cur_fb [`NUM_AXES],     // axis 1 at index 0
    output current_t   cur_cmd [`NUM_AXES],
    output axis_mask_t amp_enable,
    output reg_data_t  reg_rdata
);

    logic       bus_wen;
    reg_addr_t  bus_waddr;
    reg_data_t  bus_wdata;
    reg_addr_t  bus_raddr;
    axis_mask_t clear_disable;      // channel_regs -> safety checks
    axis_mask_t safety_disable;     // safety checks -> channel_regs

    bus_arbiter arb_i (
        .sysclk        (sysclk),
        .arst_n        (arst_n),
        .fw_reg_wen    (fw_reg_wen),
        .fw_reg_waddr  (fw_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .fw_reg_raddr  (fw_reg_raddr),
        .eth_reg_wen   (eth_reg_wen),
        .eth_reg_waddr (eth_reg_waddr),
        .eth_reg_wdata (eth_reg_wdata),
        .eth_read_en   (eth_read_en),
        .eth_reg_raddr (eth_reg_raddr),
        .bus_wen       (bus_wen),
        .bus_waddr     (bus_waddr),
        .bus_wdata     (bus_wdata),
        .bus_raddr     (bus_raddr)
    );

    channel_regs chan_i (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .bus_wen        (bus_wen),
        .bus_waddr      (bus_waddr),
        .bus_wdata      (bus_wdata),
        .bus_raddr      (bus_raddr),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .cur_cmd        (cur_cmd),
        .clear_disable  (clear_disable),
        .amp_enable     (amp_enable),
        .reg_rdata      (reg_rdata)
    );

    // ----------------------------------------------------------------------
    // one overcurrent check per axis
    // ----------------------------------------------------------------------
    for (genvar i = 0; i < `NUM_AXES; i++) begin : g_safety
        safety_check safe_i (
            .sysclk        (sysclk),
            .arst_n        (arst_n),
            .cur_fb        (cur_fb[i]),
            .cur_cmd       (cur_cmd[i]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (safety_disable[i])
        );
    end

endmodule

//--- tests/qla_reg_core_properties.sv
`timescale 1ns/100ps

`include "qla_consts.svh"

module qla_reg_core_properties import bus_pkg::*, motor_pkg::*; (
    input logic       sysclk,
    input logic       arst_n,
    input current_t   cur_cmd [`NUM_AXES],
    input axis_mask_t amp_enable,
    input reg_data_t  reg_rdata,
    input axis_mask_t clear_disable,
    input axis_mask_t safety_disable
);

    int fails = 0;      // assertion failure count

    // all outputs held low while in reset
    a_reset_outputs: assert property (@(posedge sysclk)
        !arst_n |-> (amp_enable == '0 && reg_rdata == '0 && clear_disable == '0
                     && safety_disable == '0
                     && (cur_cmd[0] | cur_cmd[1] | cur_cmd[2] | cur_cmd[3]) == '0))
        else begin
            $error("outputs not cleared during reset");
            fails++;
        end

    // a tripped axis only drops after a clear pulse
    a_disable_latch: assert property (@(posedge sysclk) disable iff (!arst_n)
        1'b1 |=> (($past(safety_disable) & ~$past(clear_disable) & ~safety_disable) == '0))
        else begin
            $error("safety disable dropped without a clear pulse");
            fails++;
        end

    a_clear_pulse: assert property (@(posedge sysclk) disable iff (!arst_n)
        1'b1 |=> (($past(clear_disable) & clear_disable) == '0))   // single cycle only
        else begin
            $error("clear pulse held longer than one cycle");
            fails++;
        end

endmodule

bind qla_reg_core qla_reg_core_properties props_i (
    .sysclk         (sysclk),
    .arst_n         (arst_n),
    .cur_cmd        (cur_cmd),
    .amp_enable     (amp_enable),
    .reg_rdata      (reg_rdata),
    .clear_disable  (clear_disable),
    .safety_disable (safety_disable)
);

//--- tests/qla_reg_core_tb.sv
`timescale 1ns/100ps

`include "qla_consts.svh"

module qla_reg_core_tb import bus_pkg::*, motor_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_FW         = 200;     // phase lengths in single-cycle ops
    localparam int N_COLL       = 120;
    localparam int N_UNMAP      = 120;
    localparam int N_SAFE       = 300;
    localparam int N_STAT       = 400;
    localparam int TOTAL_OPS    = N_FW + N_COLL + N_UNMAP + 5 + N_SAFE + N_STAT + 2;
    localparam int OP_CYCLES    = 2;       // generous bound per op
    localparam int TIMEOUT_NS   = (RESET_CYCLES + TOTAL_OPS * OP_CYCLES + 100) * 8;

    logic       sysclk;
    logic       arst_n;
    logic       fw_reg_wen, eth_reg_wen, eth_read_en;
    reg_addr_t  fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr;
    reg_data_t  fw_reg_wdata, eth_reg_wdata;
    board_id_t  board_id;
    current_t   cur_fb [`NUM_AXES];
    current_t   cur_cmd [`NUM_AXES];
    axis_mask_t amp_enable;
    reg_data_t  reg_rdata;

    // reference model state in pipeline order
    logic        m_wen;
    reg_addr_t   m_waddr, m_raddr;
    reg_data_t   m_wdata, m_rdata;
    current_t    m_dac [`NUM_AXES];
    logic        m_pwr;
    axis_mask_t  m_amp, m_dis, m_clr;
    int          m_cnt [`NUM_AXES];     // consecutive overcurrent samples
    logic [31:0] lcg_state;
    int          errors, checks;

    qla_reg_core dut_i (.*);

    always #4 sysclk = ~sysclk;

    // ------------------------------------------------------------------------
    // random numbers and address helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};    // good bits at the bottom
    endfunction

    function automatic reg_addr_t dac_addr(int axis);
        return {`ADDR_MAIN, 4'h0, 4'(axis + 1), `OFF_DAC_CTRL};
    endfunction

    // random address that hits no register and often lies in the main space
    function automatic reg_addr_t unmapped_addr(logic [31:0] r);
        reg_addr_t a;
        a = r[15:0];
        if (r[16]) a[15:12] = `ADDR_MAIN;
        if (a[15:12] == `ADDR_MAIN && ((a[7:4] == 4'h0 && a[3:0] == `REG_STATUS)
                || (a[7:4] inside {[1:4]} && a[3:0] == `OFF_DAC_CTRL))) begin
            a[12] = 1'b1;                   // push it out of the main space
        end
        return a;
    endfunction

    function automatic current_t pick_fb(current_t cmd, logic over, logic [31:0] r);
        int lim;
        lim = 2 * int'(cmd);
        if (over) return current_t'(lim + 1 + int'(r[7:0]));
        return current_t'(int'(r[15:0]) % (lim + 1));
    endfunction

    // ------------------------------------------------------------------------
    // reference model called once per rising edge
    // ------------------------------------------------------------------------
    function automatic reg_data_t model_read(reg_addr_t a);
        reg_data_t d;
        d = '0;
        if (a[`ADDR_SPACE] == `ADDR_MAIN) begin
            if (a[`ADDR_CHAN] == 4'h0 && a[`ADDR_OFF] == `REG_STATUS)
                d = {4'h0, board_id, 4'h0, m_pwr, 7'h00, m_amp, 4'h0, m_dis};  // id/pwr/amp/dis
            for (int i = 0; i < `NUM_AXES; i++)
                if (a[`ADDR_CHAN] == 4'(i + 1) && a[`ADDR_OFF] == `OFF_DAC_CTRL)
                    d = {16'h0000, m_dac[i]};
        end
        return d;
    endfunction

    task automatic model_edge();
        axis_mask_t clr_nxt;
        m_rdata = model_read(m_raddr);      // sees state before this edge
        for (int i = 0; i < `NUM_AXES; i++) begin
            if (m_clr[i]) begin
                m_cnt[i] = 0;
                m_dis[i] = 1'b0;
            end else if (int'(cur_fb[i]) > 2 * int'(m_dac[i])) begin
                if (m_cnt[i] < `SAFETY_LIMIT) m_cnt[i]++;
                if (m_cnt[i] == `SAFETY_LIMIT) m_dis[i] = 1'b1;
            end else begin
                m_cnt[i] = 0;
            end
        end
        clr_nxt = '0;
        if (m_wen && m_waddr[`ADDR_SPACE] == `ADDR_MAIN) begin
            if (m_waddr[`ADDR_CHAN] == 4'h0 && m_waddr[`ADDR_OFF] == `REG_STATUS) begin
                m_pwr   = m_wdata[19];
                m_amp   = m_wdata[11:8];
                clr_nxt = m_wdata[11:8] | {4{m_wdata[19]}};
            end
            for (int i = 0; i < `NUM_AXES; i++)
                if (m_waddr[`ADDR_CHAN] == 4'(i + 1) && m_waddr[`ADDR_OFF] == `OFF_DAC_CTRL)
                    m_dac[i] = m_wdata[15:0];
        end
        m_clr   = clr_nxt;
        m_wen   = fw_reg_wen | eth_reg_wen;
        m_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;   // ethernet wins
        m_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
        m_raddr = eth_read_en ? eth_reg_raddr : fw_reg_raddr;
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_rdata(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s reg_rdata: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input current_t exp, input current_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s cur_cmd: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input axis_mask_t exp, input axis_mask_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s amp_enable: expected %b, actual %b", name, exp, act);
        end
    endtask

    // model at the rising edge and compare at the falling edge
    task automatic step(input string name);
        @(posedge sysclk);
        model_edge();
        @(negedge sysclk);
        for (int i = 0; i < `NUM_AXES; i++) check_cmd(name, m_dac[i], cur_cmd[i]);
        check_mask(name, m_amp & {4{m_pwr}} & ~m_dis, amp_enable);
        check_rdata(name, m_rdata, reg_rdata);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] r;
        int          hold;
        logic        prev_stat;
        lcg_state = 32'h11647acb;
        errors = 0;
        checks = 0;
        sysclk = 1'b0;
        arst_n = 1'b1;
        {fw_reg_wen, eth_reg_wen, eth_read_en} = '0;
        {fw_reg_waddr, fw_reg_raddr, eth_reg_waddr, eth_reg_raddr} = '0;
        {fw_reg_wdata, eth_reg_wdata} = '0;
        board_id = 4'hb;
        {m_wen, m_waddr, m_raddr, m_wdata, m_rdata, m_pwr, m_amp, m_dis, m_clr} = '0;
        for (int i = 0; i < `NUM_AXES; i++) begin
            cur_fb[i] = '0;
            m_dac[i]  = '0;
            m_cnt[i]  = 0;
        end
        #1 arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        arst_n = 1'b1;

        for (int n = 0; n < N_FW; n++) begin       // firewire dac writes and reads
            r = lcg_next();
            fw_reg_wen   = r[0];
            fw_reg_waddr = dac_addr(r[2:1]);
            fw_reg_wdata = lcg_next();
            fw_reg_raddr = dac_addr(r[4:3]);
            step("fw_dac");
        end

        for (int n = 0; n < N_COLL; n++) begin     // both masters at once
            r = lcg_next();
            fw_reg_wen    = r[0];
            eth_reg_wen   = r[1];
            fw_reg_waddr  = dac_addr(r[3:2]);
            eth_reg_waddr = dac_addr(r[5:4]);
            fw_reg_wdata  = lcg_next();
            eth_reg_wdata = lcg_next();
            eth_read_en   = r[6];
            fw_reg_raddr  = r[7] ? 16'h0000 : dac_addr(r[9:8]);
            eth_reg_raddr = dac_addr(r[11:10]);
            step("collide");
        end
        {eth_reg_wen, eth_read_en} = '0;

        for (int n = 0; n < N_UNMAP; n++) begin
            fw_reg_wen   = 1'b1;
            fw_reg_waddr = unmapped_addr(lcg_next());
            fw_reg_wdata = lcg_next();
            fw_reg_raddr = unmapped_addr(lcg_next());
            step("unmapped");
        end

        // small commands so overcurrent is easy to reach
        for (int i = 0; i < `NUM_AXES; i++) begin
            fw_reg_waddr = dac_addr(i);
            fw_reg_wdata = lcg_next() & 32'h0000_0fff;
            step("safety_setup");
        end
        fw_reg_waddr = 16'h0000;
        fw_reg_wdata = 32'h0008_0f00;                // power on and all amps enabled
        step("safety_setup");
        fw_reg_wen   = 1'b0;
        fw_reg_raddr = 16'h0000;
        hold = 0;
        for (int n = 0; n < N_SAFE; n++) begin
            if (hold == 0) begin
                r = lcg_next();
                for (int i = 0; i < `NUM_AXES; i++) begin
                    cur_fb[i] = pick_fb(m_dac[i], r[i], lcg_next());
                end
                hold = 1 + int'(r[7:4]);            // 1..16 cycles
            end
            hold--;
            step("safety");
        end

        prev_stat = 1'b0;
        for (int n = 0; n < N_STAT; n++) begin     // status writes re-arm axes
            r = lcg_next();
            fw_reg_wen   = !prev_stat && r[1:0] == 2'b00;   // never back to back
            fw_reg_waddr = 16'h0000;
            fw_reg_wdata = lcg_next();
            prev_stat    = fw_reg_wen;
            fw_reg_raddr = r[2] ? 16'h0000 : dac_addr(r[4:3]);
            if (r[7:5] == 3'b000) begin
                for (int i = 0; i < `NUM_AXES; i++) begin
                    cur_fb[i] = pick_fb(m_dac[i], r[8 + i], lcg_next());
                end
            end
            step("status");
        end
        fw_reg_wen = 1'b0;
        step("drain");
        step("drain");

        $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, dut_i.props_i.fails);
        if (errors == 0 && dut_i.props_i.fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+hw
hw/bus_pkg.sv
hw/motor_pkg.sv
hw/bus_arbiter.sv
hw/channel_regs.sv
hw/safety_check.sv
hw/qla_reg_core.sv
tests/qla_reg_core_properties.sv
tests/qla_reg_core_tb.sv
